/* design/be_settings.svh */
//////////////////////////////////////////////////
// Widths, depths and RV32 encodings of the execute
// back end. BE_MUL_LATENCY has to equal
// BE_COMP_STAGES since the product lands in the
// commit stage
//////////////////////////////////////////////////
`ifndef BE_SETTINGS_SVH
`define BE_SETTINGS_SVH

`define BE_XLEN        32
`define BE_REG_ADDR_W  5
`define BE_COMP_STAGES 3
`define BE_MUL_LATENCY 3

// Major opcodes
`define BE_OPC_OP     7'b0110011
`define BE_OPC_OP_IMM 7'b0010011

`define BE_F3_ADD_SUB 3'b000
`define BE_F3_SLL     3'b001
`define BE_F3_SLT     3'b010
`define BE_F3_SLTU    3'b011
`define BE_F3_XOR     3'b100
`define BE_F3_SRL_SRA 3'b101
`define BE_F3_OR      3'b110
`define BE_F3_AND     3'b111
`define BE_F3_MUL     3'b000

`define BE_F7_BASE    7'b0000000
`define BE_F7_ALT     7'b0100000
`define BE_F7_MULDIV  7'b0000001

`endif

/* design/be_pkg.sv */
//////////////////////////////////////////////////
// Instruction word views for the RV32 integer
// subset. Both views are 32 bits wide only with
// 5-bit register addresses
//////////////////////////////////////////////////
`include "be_settings.svh"

package be_pkg;

  // Same word seen as register-register or register-immediate form
  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [`BE_REG_ADDR_W-1:0] rs2;
      logic [`BE_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`BE_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } rtype;
    struct packed {
      logic [11:0]               imm12;
      logic [`BE_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`BE_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } itype;
  } instr_u;

endpackage

/* design/issue_stage.sv */
//////////////////////////////////////////////////
// Decode, operand bypass and reservation register.
// Forward source 0 is the execute stage and is the
// youngest. Register 0 is never forwarded
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module issue_stage (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         dispatch_v_i,
  input  logic                                         flush_i,
  input  be_pkg::instr_u                               instr_i,
  input  logic [`BE_XLEN-1:0]                          rs1_data_i,
  input  logic [`BE_XLEN-1:0]                          rs2_data_i,
  input  logic [`BE_COMP_STAGES:0][`BE_REG_ADDR_W-1:0] fwd_rd_addr_i,
  input  logic [`BE_COMP_STAGES:0]                     fwd_w_v_i,
  input  logic [`BE_COMP_STAGES:0][`BE_XLEN-1:0]       fwd_data_i,
  output be_pkg::instr_u                               ex_instr_o,
  output logic [`BE_XLEN-1:0]                          ex_op_a_o,
  output logic [`BE_XLEN-1:0]                          ex_op_b_o,
  output logic                                         ex_int_v_o,
  output logic                                         ex_mul_v_o,
  output logic                                         ex_rd_w_v_o
);
  import be_pkg::*;

  localparam int unsigned src_cnt_lp = `BE_COMP_STAGES + 1;

  logic                  is_op;
  logic                  is_op_imm;
  logic                  is_mul;
  logic                  is_int;
  logic                  alt_ok;
  logic                  int_v;
  logic                  mul_v;
  logic                  rd_w_v;
  logic [src_cnt_lp-1:0] match_rs1;
  logic [src_cnt_lp-1:0] match_rs2;
  logic [`BE_XLEN-1:0]   bypass_rs1;
  logic [`BE_XLEN-1:0]   bypass_rs2;
  logic [`BE_XLEN-1:0]   imm_sext;
  logic [`BE_XLEN-1:0]   op_b;

  instr_u                instr_r;
  logic [`BE_XLEN-1:0]   op_a_r;
  logic [`BE_XLEN-1:0]   op_b_r;
  logic                  int_v_r;
  logic                  mul_v_r;
  logic                  rd_w_v_r;

  assign is_op     = (instr_i.rtype.opcode == `BE_OPC_OP);
  assign is_op_imm = (instr_i.itype.opcode == `BE_OPC_OP_IMM);

  // Only MUL is kept from the M extension
  assign is_mul = is_op
                & (instr_i.rtype.funct7 == `BE_F7_MULDIV)
                & (instr_i.rtype.funct3 == `BE_F3_MUL);

  // funct7 0100000 is legal only for SUB and SRA
  assign alt_ok = (instr_i.rtype.funct3 == `BE_F3_ADD_SUB)
                | (instr_i.rtype.funct3 == `BE_F3_SRL_SRA);

  always_comb
  begin
    is_int = 1'b0;
    if (is_op)
    begin
      is_int = (instr_i.rtype.funct7 == `BE_F7_BASE)
             | ((instr_i.rtype.funct7 == `BE_F7_ALT) & alt_ok);
    end
    else if (is_op_imm)
    begin
      case (instr_i.itype.funct3)
        `BE_F3_SLL:     is_int = (instr_i.rtype.funct7 == `BE_F7_BASE);
        `BE_F3_SRL_SRA: is_int = (instr_i.rtype.funct7 == `BE_F7_BASE)
                               | (instr_i.rtype.funct7 == `BE_F7_ALT);
        default:        is_int = 1'b1;
      endcase
    end
  end

  assign int_v  = dispatch_v_i & ~flush_i & is_int;
  assign mul_v  = dispatch_v_i & ~flush_i & is_mul;
  assign rd_w_v = (int_v | mul_v) & (instr_i.rtype.rd != '0);

  for (genvar i = 0; i < src_cnt_lp; i++)
  begin : g_match
    assign match_rs1[i] = fwd_w_v_i[i] & (instr_i.rtype.rs1 != '0)
                        & (fwd_rd_addr_i[i] == instr_i.rtype.rs1);
    assign match_rs2[i] = fwd_w_v_i[i] & (instr_i.rtype.rs2 != '0)
                        & (fwd_rd_addr_i[i] == instr_i.rtype.rs2);
  end

  // Walk from oldest to youngest so the youngest match wins
  always_comb
  begin
    bypass_rs1 = rs1_data_i;
    bypass_rs2 = rs2_data_i;
    for (int i = src_cnt_lp - 1; i >= 0; i--)
    begin
      if (match_rs1[i])
        bypass_rs1 = fwd_data_i[i];
      if (match_rs2[i])
        bypass_rs2 = fwd_data_i[i];
    end
  end

  assign imm_sext = {{(`BE_XLEN-12){instr_i.itype.imm12[11]}}, instr_i.itype.imm12};
  assign op_b     = is_op_imm ? imm_sext : bypass_rs2;

  always_ff @(posedge clk_i)
  begin
    instr_r <= instr_i;
    op_a_r  <= bypass_rs1;
    op_b_r  <= op_b;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      int_v_r  <= 1'b0;
      mul_v_r  <= 1'b0;
      rd_w_v_r <= 1'b0;
    end
    else
    begin
      int_v_r  <= int_v;
      mul_v_r  <= mul_v;
      rd_w_v_r <= rd_w_v;
    end
  end

  assign ex_instr_o  = instr_r;
  assign ex_op_a_o   = op_a_r;
  assign ex_op_b_o   = op_b_r;
  assign ex_int_v_o  = int_v_r;
  assign ex_mul_v_o  = mul_v_r;
  assign ex_rd_w_v_o = rd_w_v_r;

endmodule

/* design/pipe_int.sv */
//////////////////////////////////////////////////
// Single-cycle integer ALU, purely combinational.
// Result is meaningful only while the execute
// stage holds an integer instruction
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module pipe_int (
  input  be_pkg::instr_u      instr_i,
  input  logic [`BE_XLEN-1:0] op_a_i,
  input  logic [`BE_XLEN-1:0] op_b_i,
  output logic [`BE_XLEN-1:0] data_o
);

  logic                       is_sub;
  logic                       is_sra;
  logic [4:0]                 shamt;
  logic                       lt_signed;
  logic                       lt_unsigned;
  logic signed [`BE_XLEN-1:0] sra_res;
  logic [`BE_XLEN-1:0]        srl_res;

  // No SUBI exists, so bit 30 selects SUB only in the register form
  assign is_sub = (instr_i.rtype.opcode == `BE_OPC_OP) & instr_i.rtype.funct7[5];

  // SRAI carries the same bit 30 in its immediate
  assign is_sra = instr_i.rtype.funct7[5];

  assign shamt = op_b_i[4:0];

  assign lt_signed   = ($signed(op_a_i) < $signed(op_b_i));
  assign lt_unsigned = (op_a_i < op_b_i);

  assign sra_res = $signed(op_a_i) >>> shamt;
  assign srl_res = op_a_i >> shamt;

  always_comb
  begin
    case (instr_i.rtype.funct3)
      `BE_F3_ADD_SUB: data_o = is_sub ? (op_a_i - op_b_i) : (op_a_i + op_b_i);
      `BE_F3_SLL:     data_o = op_a_i << shamt;
      `BE_F3_SLT:     data_o = {{(`BE_XLEN-1){1'b0}}, lt_signed};
      `BE_F3_SLTU:    data_o = {{(`BE_XLEN-1){1'b0}}, lt_unsigned};
      `BE_F3_XOR:     data_o = op_a_i ^ op_b_i;
      `BE_F3_SRL_SRA: data_o = is_sra ? sra_res : srl_res;
      `BE_F3_OR:      data_o = op_a_i | op_b_i;
      `BE_F3_AND:     data_o = op_a_i & op_b_i;
      default:        data_o = '0;
    endcase
  end

endmodule

/* design/pipe_mul.sv */
//////////////////////////////////////////////////
// Pipelined multiplier returning the low word.
// Product is ready in the third execute cycle and
// the last completion stage captures it
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module pipe_mul (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                v_i,
  input  logic [`BE_XLEN-1:0] op_a_i,
  input  logic [`BE_XLEN-1:0] op_b_i,
  output logic [`BE_XLEN-1:0] data_o,
  output logic                v_o
);

  // First cycle multiplies at the inputs, the rest are register stages
  localparam int unsigned depth_lp = `BE_MUL_LATENCY - 1;

  logic [`BE_XLEN-1:0]               prod_lo;
  logic [depth_lp-1:0]               v_r;
  logic [depth_lp-1:0][`BE_XLEN-1:0] prod_r;

  // Low word is identical for signed and unsigned operands
  assign prod_lo = op_a_i * op_b_i;

  always_ff @(posedge clk_i)
  begin
    prod_r[0] <= prod_lo;
    for (int i = 1; i < depth_lp; i++)
      prod_r[i] <= prod_r[i-1];
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r[0] <= v_i;
      for (int i = 1; i < depth_lp; i++)
        v_r[i] <= v_r[i-1];
    end
  end

  assign data_o = prod_r[depth_lp-1];
  assign v_o    = v_r[depth_lp-1];

endmodule

/* design/completion_pipe.sv */
//////////////////////////////////////////////////
// Shifting completion stages. The last stage is the
// commit point and is never flushed. Results of
// the execute entry and every stage are forwarded
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module completion_pipe (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         flush_i,
  input  logic                                         ex_v_i,
  input  logic [`BE_REG_ADDR_W-1:0]                    ex_rd_addr_i,
  input  logic                                         int_v_i,
  input  logic [`BE_XLEN-1:0]                          int_data_i,
  input  logic                                         mul_v_i,
  input  logic [`BE_XLEN-1:0]                          mul_data_i,
  output logic [`BE_COMP_STAGES:0][`BE_REG_ADDR_W-1:0] fwd_rd_addr_o,
  output logic [`BE_COMP_STAGES:0]                     fwd_w_v_o,
  output logic [`BE_COMP_STAGES:0][`BE_XLEN-1:0]       fwd_data_o,
  output logic                                         wb_v_o,
  output logic [`BE_REG_ADDR_W-1:0]                    wb_rd_addr_o,
  output logic [`BE_XLEN-1:0]                          wb_data_o
);

  localparam int unsigned stages_lp = `BE_COMP_STAGES;

  logic [`BE_XLEN-1:0]                      ex_data;
  logic [stages_lp-1:0]                     w_v_n;
  logic [stages_lp-1:0][`BE_REG_ADDR_W-1:0] rd_addr_n;
  logic [stages_lp-1:0][`BE_XLEN-1:0]       data_n;
  logic [stages_lp-1:0]                     w_v_r;
  logic [stages_lp-1:0][`BE_REG_ADDR_W-1:0] rd_addr_r;
  logic [stages_lp-1:0][`BE_XLEN-1:0]       data_r;

  // A multiply carries zero until its product arrives
  assign ex_data = int_v_i ? int_data_i : '0;

  always_comb
  begin
    w_v_n     = {w_v_r[stages_lp-2:0], ex_v_i};
    rd_addr_n = {rd_addr_r[stages_lp-2:0], ex_rd_addr_i};
    data_n    = {data_r[stages_lp-2:0], ex_data};

    // Product lands as its entry moves into the commit stage
    if (mul_v_i)
      data_n[stages_lp-1] = mul_data_i;

    // Kill everything that has not reached commit
    for (int i = 0; i < stages_lp - 1; i++)
      w_v_n[i] = w_v_n[i] & ~flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    rd_addr_r <= rd_addr_n;
    data_r    <= data_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      w_v_r <= '0;
    else
      w_v_r <= w_v_n;
  end

  // Source 0 is the execute entry, youngest first
  assign fwd_rd_addr_o = {rd_addr_r, ex_rd_addr_i};
  assign fwd_w_v_o     = {w_v_r, ex_v_i};
  assign fwd_data_o    = {data_r, ex_data};

  assign wb_v_o       = w_v_r[stages_lp-1];
  assign wb_rd_addr_o = rd_addr_r[stages_lp-1];
  assign wb_data_o    = data_r[stages_lp-1];

endmodule

/* design/calc_top.sv */
//////////////////////////////////////////////////
// Execute back end top. No stall logic exists.
// A consumer of a multiply must be dispatched 4 or
// more cycles after it. Writeback is 4 cycles
// after dispatch for every instruction
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module calc_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      dispatch_v_i,
  input  be_pkg::instr_u            instr_i,
  input  logic [`BE_XLEN-1:0]       rs1_data_i,
  input  logic [`BE_XLEN-1:0]       rs2_data_i,
  input  logic                      flush_i,
  output logic                      wb_v_o,
  output logic [`BE_REG_ADDR_W-1:0] wb_rd_addr_o,
  output logic [`BE_XLEN-1:0]       wb_data_o
);
  import be_pkg::*;

  instr_u                                       ex_instr;
  logic [`BE_XLEN-1:0]                          ex_op_a;
  logic [`BE_XLEN-1:0]                          ex_op_b;
  logic                                         ex_int_v;
  logic                                         ex_mul_v;
  logic                                         ex_rd_w_v;
  logic [`BE_XLEN-1:0]                          int_data;
  logic [`BE_XLEN-1:0]                          mul_data;
  logic                                         mul_v;
  logic [`BE_COMP_STAGES:0][`BE_REG_ADDR_W-1:0] fwd_rd_addr;
  logic [`BE_COMP_STAGES:0]                     fwd_w_v;
  logic [`BE_COMP_STAGES:0][`BE_XLEN-1:0]       fwd_data;

  issue_stage issue_stage_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dispatch_v_i  (dispatch_v_i),
    .flush_i       (flush_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .fwd_rd_addr_i (fwd_rd_addr),
    .fwd_w_v_i     (fwd_w_v),
    .fwd_data_i    (fwd_data),
    .ex_instr_o    (ex_instr),
    .ex_op_a_o     (ex_op_a),
    .ex_op_b_o     (ex_op_b),
    .ex_int_v_o    (ex_int_v),
    .ex_mul_v_o    (ex_mul_v),
    .ex_rd_w_v_o   (ex_rd_w_v)
  );

  pipe_int pipe_int_i (
    .instr_i (ex_instr),
    .op_a_i  (ex_op_a),
    .op_b_i  (ex_op_b),
    .data_o  (int_data)
  );

  pipe_mul pipe_mul_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (ex_mul_v),
    .op_a_i  (ex_op_a),
    .op_b_i  (ex_op_b),
    .data_o  (mul_data),
    .v_o     (mul_v)
  );

  completion_pipe completion_pipe_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .ex_v_i        (ex_rd_w_v),
    .ex_rd_addr_i  (ex_instr.rtype.rd),
    .int_v_i       (ex_int_v),
    .int_data_i    (int_data),
    .mul_v_i       (mul_v),
    .mul_data_i    (mul_data),
    .fwd_rd_addr_o (fwd_rd_addr),
    .fwd_w_v_o     (fwd_w_v),
    .fwd_data_o    (fwd_data),
    .wb_v_o        (wb_v_o),
    .wb_rd_addr_o  (wb_rd_addr_o),
    .wb_data_o     (wb_data_o)
  );

endmodule

/* verif/tb_calc_table.svh */
//////////////////////////////////////////////////
// One row per cycle: instruction, dispatch valid,
// flush, then expected writeback valid, rd, data.
// Expected data is worked out by hand
//////////////////////////////////////////////////
`ifndef TB_CALC_TABLE_SVH
`define TB_CALC_TABLE_SVH

task automatic fill_table();
  // Seed registers x1 = 100, x2 = -7, x3 = 0x7ff
  add_row(enc_i(12'd100, 5'd0, `BE_F3_ADD_SUB, 5'd1), 1, 0, 1, 5'd1, 32'h0000_0064);
  add_row(enc_i(12'hff9, 5'd0, `BE_F3_ADD_SUB, 5'd2), 1, 0, 1, 5'd2, 32'hffff_fff9);
  add_row(enc_i(12'h7ff, 5'd0, `BE_F3_ADD_SUB, 5'd3), 1, 0, 1, 5'd3, 32'h0000_07ff);
  add_row('0, 0, 0, 0, 5'd0, 32'h0);
  add_row('0, 0, 0, 0, 5'd0, 32'h0);
  add_row('0, 0, 0, 0, 5'd0, 32'h0);
  // Register ALU ops
  add_row(enc_r(`BE_F7_BASE, 5'd2, 5'd1, `BE_F3_ADD_SUB, 5'd4), 1, 0, 1, 5'd4, 32'h0000_005d);
  add_row(enc_r(`BE_F7_ALT, 5'd2, 5'd1, `BE_F3_ADD_SUB, 5'd5), 1, 0, 1, 5'd5, 32'h0000_006b);
  add_row(enc_r(`BE_F7_BASE, 5'd1, 5'd2, `BE_F3_SLT, 5'd6), 1, 0, 1, 5'd6, 32'h0000_0001);
  add_row(enc_r(`BE_F7_BASE, 5'd1, 5'd2, `BE_F3_SLTU, 5'd7), 1, 0, 1, 5'd7, 32'h0000_0000);
  add_row(enc_r(`BE_F7_BASE, 5'd1, 5'd3, `BE_F3_SLL, 5'd8), 1, 0, 1, 5'd8, 32'h0000_7ff0);
  add_row(enc_r(`BE_F7_BASE, 5'd1, 5'd2, `BE_F3_SRL_SRA, 5'd9), 1, 0, 1, 5'd9, 32'h0fff_ffff);
  add_row(enc_r(`BE_F7_ALT, 5'd1, 5'd2, `BE_F3_SRL_SRA, 5'd10), 1, 0, 1, 5'd10, 32'hffff_ffff);
  add_row(enc_r(`BE_F7_BASE, 5'd3, 5'd1, `BE_F3_XOR, 5'd11), 1, 0, 1, 5'd11, 32'h0000_079b);
  add_row(enc_r(`BE_F7_BASE, 5'd2, 5'd1, `BE_F3_OR, 5'd12), 1, 0, 1, 5'd12, 32'hffff_fffd);
  add_row(enc_r(`BE_F7_BASE, 5'd2, 5'd3, `BE_F3_AND, 5'd13), 1, 0, 1, 5'd13, 32'h0000_07f9);
  // Immediate ops, negative immediates sign-extended
  add_row(enc_i(12'h0f0, 5'd3, `BE_F3_AND, 5'd14), 1, 0, 1, 5'd14, 32'h0000_00f0);
  add_row(enc_i(12'hfff, 5'd1, `BE_F3_XOR, 5'd15), 1, 0, 1, 5'd15, 32'hffff_ff9b);
  add_row(enc_i(12'hffa, 5'd2, `BE_F3_SLT, 5'd16), 1, 0, 1, 5'd16, 32'h0000_0001);
  add_row(enc_i(12'hfff, 5'd1, `BE_F3_SLTU, 5'd17), 1, 0, 1, 5'd17, 32'h0000_0001);
  add_row(enc_i(12'h401, 5'd2, `BE_F3_SRL_SRA, 5'd18), 1, 0, 1, 5'd18, 32'hffff_fffc);
  add_row(enc_i(12'h003, 5'd1, `BE_F3_SLL, 5'd19), 1, 0, 1, 5'd19, 32'h0000_0320);
  add_row(enc_i(12'h800, 5'd0, `BE_F3_OR, 5'd20), 1, 0, 1, 5'd20, 32'hffff_f800);
  // Dependent chain, x21 written twice in flight
  add_row(enc_i(12'd5, 5'd0, `BE_F3_ADD_SUB, 5'd21), 1, 0, 1, 5'd21, 32'h0000_0005);
  add_row(enc_i(12'd1, 5'd21, `BE_F3_ADD_SUB, 5'd21), 1, 0, 1, 5'd21, 32'h0000_0006);
  add_row(enc_r(`BE_F7_BASE, 5'd21, 5'd21, `BE_F3_ADD_SUB, 5'd22), 1, 0, 1, 5'd22, 32'h0000_000c);
  add_row(enc_r(`BE_F7_BASE, 5'd22, 5'd21, `BE_F3_ADD_SUB, 5'd23), 1, 0, 1, 5'd23, 32'h0000_0012);
  add_row(enc_r(`BE_F7_ALT, 5'd21, 5'd23, `BE_F3_ADD_SUB, 5'd24), 1, 0, 1, 5'd24, 32'h0000_000c);
  add_row(enc_r(`BE_F7_BASE, 5'd22, 5'd21, `BE_F3_ADD_SUB, 5'd25), 1, 0, 1, 5'd25, 32'h0000_0012);
  add_row('0, 0, 0, 0, 5'd0, 32'h0);
  // Multiplies back to back, wrap on overflow
  add_row(enc_i(12'h001, 5'd20, `BE_F3_SRL_SRA, 5'd26), 1, 0, 1, 5'd26, 32'h7fff_fc00);
  add_row(enc_r(`BE_F7_MULDIV, 5'd26, 5'd26, `BE_F3_MUL, 5'd27), 1, 0, 1, 5'd27, 32'h0010_0000);
  add_row(enc_r(`BE_F7_MULDIV, 5'd2, 5'd26, `BE_F3_MUL, 5'd28), 1, 0, 1, 5'd28, 32'h8000_1c00);
  add_row(enc_r(`BE_F7_MULDIV, 5'd2, 5'd1, `BE_F3_MUL, 5'd29), 1, 0, 1, 5'd29, 32'hffff_fd44);
  // x0 destination, then unsupported encodings
  add_row(enc_i(12'd55, 5'd1, `BE_F3_ADD_SUB, 5'd0), 1, 0, 0, 5'd0, 32'h0);
  add_row(enc_r(`BE_F7_BASE, 5'd1, 5'd0, `BE_F3_ADD_SUB, 5'd31), 1, 0, 1, 5'd31, 32'h0000_0064);
  add_row(32'h0000_0283, 1, 0, 0, 5'd0, 32'h0);
  add_row(enc_r(`BE_F7_ALT, 5'd2, 5'd1, `BE_F3_XOR, 5'd6), 1, 0, 0, 5'd0, 32'h0);
  add_row(enc_r(`BE_F7_BASE, 5'd28, 5'd27, `BE_F3_ADD_SUB, 5'd30), 1, 0, 1, 5'd30, 32'h8010_1c00);
  add_row('0, 0, 0, 0, 5'd0, 32'h0);
  // Flush in row 43 kills rows 41 to 43 only
  add_row(enc_i(12'd1, 5'd0, `BE_F3_ADD_SUB, 5'd7), 1, 0, 1, 5'd7, 32'h0000_0001);
  add_row(enc_i(12'd2, 5'd0, `BE_F3_ADD_SUB, 5'd8), 1, 0, 0, 5'd0, 32'h0);
  add_row(enc_i(12'd3, 5'd0, `BE_F3_ADD_SUB, 5'd9), 1, 0, 0, 5'd0, 32'h0);
  add_row(enc_i(12'd4, 5'd0, `BE_F3_ADD_SUB, 5'd10), 1, 1, 0, 5'd0, 32'h0);
  add_row(enc_r(`BE_F7_BASE, 5'd7, 5'd8, `BE_F3_ADD_SUB, 5'd11), 1, 0, 1, 5'd11, 32'h0000_7ff1);
endtask

`endif

/* verif/tb_calc_top.sv */
//////////////////////////////////////////////////
// Testbench for calc_top. One table row is applied
// per cycle and its writeback is checked 4 cycles
// later. The register file lives here, not in the DUT
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "be_settings.svh"

module tb_calc_top;
  import be_pkg::*;

  localparam int max_rows_lp = 64;
  localparam int drain_limit_lp = 16;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      dispatch_v_i;
  instr_u                    instr_i;
  logic [`BE_XLEN-1:0]       rs1_data_i;
  logic [`BE_XLEN-1:0]       rs2_data_i;
  logic                      flush_i;
  logic                      wb_v_o;
  logic [`BE_REG_ADDR_W-1:0] wb_rd_addr_o;
  logic [`BE_XLEN-1:0]       wb_data_o;

  instr_u                    tab_instr [max_rows_lp];
  logic                      tab_dv    [max_rows_lp];
  logic                      tab_fl    [max_rows_lp];
  logic                      tab_ev    [max_rows_lp];
  logic [`BE_REG_ADDR_W-1:0] tab_rd    [max_rows_lp];
  logic [`BE_XLEN-1:0]       tab_data  [max_rows_lp];
  logic [`BE_XLEN-1:0]       regs      [32];
  int                        num_rows;
  int                        errors;
  int                        next_chk;
  int                        drain_cycles;
  logic                      timed_out;

  calc_top dut_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dispatch_v_i (dispatch_v_i),
    .instr_i      (instr_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .flush_i      (flush_i),
    .wb_v_o       (wb_v_o),
    .wb_rd_addr_o (wb_rd_addr_o),
    .wb_data_o    (wb_data_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic instr_u enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    instr_u w;
    w.rtype.funct7 = f7;
    w.rtype.rs2    = rs2;
    w.rtype.rs1    = rs1;
    w.rtype.funct3 = f3;
    w.rtype.rd     = rd;
    w.rtype.opcode = `BE_OPC_OP;
    return w;
  endfunction

  function automatic instr_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd);
    instr_u w;
    w.itype.imm12  = imm;
    w.itype.rs1    = rs1;
    w.itype.funct3 = f3;
    w.itype.rd     = rd;
    w.itype.opcode = `BE_OPC_OP_IMM;
    return w;
  endfunction

  task automatic add_row(input instr_u ins, input logic dv, input logic fl,
                         input logic ev, input logic [4:0] rd, input logic [31:0] data);
    tab_instr[num_rows] = ins;
    tab_dv[num_rows]    = dv;
    tab_fl[num_rows]    = fl;
    tab_ev[num_rows]    = ev;
    tab_rd[num_rows]    = rd;
    tab_data[num_rows]  = data;
    num_rows++;
  endtask

  `include "tb_calc_table.svh"

  // Row < 0 means nothing was dispatched, so the writeback must be idle
  task automatic check_wb(input int row);
    logic ev;
    ev = (row >= 0) ? tab_ev[row] : 1'b0;
    assert (wb_v_o === ev)
    else
    begin
      $display("ERR wb_v_o row %0d got %h exp %h", row, wb_v_o, ev);
      errors++;
    end
    if (ev)
    begin
      assert (wb_rd_addr_o === tab_rd[row])
      else
      begin
        $display("ERR wb_rd_addr_o row %0d got %h exp %h", row, wb_rd_addr_o, tab_rd[row]);
        errors++;
      end
      assert (wb_data_o === tab_data[row])
      else
      begin
        $display("ERR wb_data_o row %0d got %h exp %h", row, wb_data_o, tab_data[row]);
        errors++;
      end
    end
  endtask

  // Writeback reaches the register file at the end of its cycle
  task automatic update_regfile();
    if (wb_v_o === 1'b1 && wb_rd_addr_o != '0)
      regs[wb_rd_addr_o] = wb_data_o;
  endtask

  task automatic drive_row(input int row);
    instr_i      = tab_instr[row];
    dispatch_v_i = tab_dv[row];
    flush_i      = tab_fl[row];
    rs1_data_i   = regs[tab_instr[row].rtype.rs1];
    rs2_data_i   = regs[tab_instr[row].rtype.rs2];
  endtask

  task automatic drive_idle();
    instr_i      = '0;
    dispatch_v_i = 1'b0;
    flush_i      = 1'b0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
  endtask

  initial
  begin
    rst_n_i   = 1'b0;
    errors    = 0;
    num_rows  = 0;
    timed_out = 1'b0;
    drive_idle();
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    fill_table();

    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle after reset
    repeat (8)
    begin
      @(negedge clk_i);
      check_wb(-1);
    end

    // Operands are read before the writeback shown in the same cycle lands
    for (int k = 0; k < num_rows; k++)
    begin
      @(negedge clk_i);
      check_wb(k - 4);
      drive_row(k);
      update_regfile();
    end

    next_chk     = num_rows - 4;
    drain_cycles = 0;
    while (next_chk < num_rows && !timed_out)
    begin
      @(negedge clk_i);
      drive_idle();
      check_wb(next_chk);
      update_regfile();
      next_chk++;
      drain_cycles++;
      if (drain_cycles > drain_limit_lp)
      begin
        $display("Timeout while draining the pipeline");
        timed_out = 1'b1;
      end
    end

    $display("errors: %0d", errors);
    if (errors == 0 && !timed_out)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* calc_top.f */
+incdir+design
+incdir+verif
design/be_pkg.sv
design/issue_stage.sv
design/pipe_int.sv
design/pipe_mul.sv
design/completion_pipe.sv
design/calc_top.sv
verif/tb_calc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f calc_top.f \
  --top-module tb_calc_top \
  -o tb_calc_top_sim

out="$(./obj_dir/tb_calc_top_sim)"
echo "$out"

if grep -q "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1
